/* logic/cluster_pkg.sv */
`default_nettype none

package cluster_pkg;

  // cluster size
  localparam int num_cores = 4;
  // word memory geometry
  localparam int addr_w = 6;
  localparam int data_w = 16;
  localparam int mem_depth = 64;
  // bridge power-up length in cycles
  localparam int boot_steps = 5;

  typedef logic [addr_w-1:0] addr_t;
  typedef logic [data_w-1:0] data_t;
  // one slot per core, polled in turn
  typedef logic [$clog2(num_cores)-1:0] slot_t;
  // position among running cores, by start order
  typedef logic [$clog2(num_cores)-1:0] rank_t;
  typedef logic [1:0] alu_op_t;
  // power-up step count, must reach boot_steps
  typedef logic [$clog2(boot_steps+1)-1:0] boot_cnt_t;

  // job operations
  localparam alu_op_t alu_add = 2'd0;
  localparam alu_op_t alu_sub = 2'd1;
  localparam alu_op_t alu_xor = 2'd2;
  localparam alu_op_t alu_and = 2'd3;

  // sequencer walk, one job at a time
  typedef enum logic [2:0] {
    wait_for_start,
    start_begin,
    read_src0,
    read_src1,
    alu_begin,
    write_dst,
    finish_begin,
    finish_end
  } seq_state_t;

  // broadcast message kinds
  typedef enum logic [1:0] {
    msg_none,
    msg_start,
    msg_end
  } msg_kind_t;

  // 20 bit job word
  typedef struct packed {
    alu_op_t op;
    addr_t   src0;
    addr_t   src1;
    addr_t   dst;
  } job_t;

  // per-slot request, all zero when idle
  typedef struct packed {
    logic      rd;
    logic      wr;
    msg_kind_t msg_kind;
    addr_t     addr;
    data_t     wdata;
  } bus_req_t;

  typedef struct packed {
    logic  done;
    data_t rdata;
  } bus_rsp_t;

  typedef struct packed {
    msg_kind_t kind;
    slot_t     src;
  } cpu_msg_t;

endpackage

`default_nettype wire

/* logic/core_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module core_sequencer (
  input  wire                      clk,
  input  wire                      ext_rst_b,
  input  wire                      core_rst,
  input  wire                      job_start,
  input  wire cluster_pkg::job_t   job_in,
  output cluster_pkg::seq_state_t  seq_state,
  output logic                     rd_q,
  output logic                     wr_q,
  output cluster_pkg::addr_t       addr,
  output cluster_pkg::data_t       wdata,
  input  wire                      rd_dn,
  input  wire                      wr_dn,
  input  wire                      msg_dn,
  input  wire cluster_pkg::data_t  rdata,
  output logic                     job_done
);

  import cluster_pkg::*;

  seq_state_t state_q;
  job_t       job_q;
  data_t      op0_q;
  data_t      op1_q;
  data_t      result_q;
  data_t      alu_res;

  // state walk, each bus step waits for its done pulse
  always_ff @(posedge clk) begin
    if (ext_rst_b || core_rst) begin
      state_q <= wait_for_start;
    end else begin
      case (state_q)
        wait_for_start: if (job_start) state_q <= start_begin;
        start_begin:    if (msg_dn) state_q <= read_src0;
        read_src0:      if (rd_dn) state_q <= read_src1;
        read_src1:      if (rd_dn) state_q <= alu_begin;
        // alu takes one cycle
        alu_begin:      state_q <= write_dst;
        write_dst:      if (wr_dn) state_q <= finish_begin;
        finish_begin:   if (msg_dn) state_q <= finish_end;
        default:        state_q <= wait_for_start;
      endcase
    end
  end

  // job word and operands
  always_ff @(posedge clk) begin
    if (state_q == wait_for_start && job_start) begin
      job_q <= job_in;
    end
    if (state_q == read_src0 && rd_dn) begin
      op0_q <= rdata;
    end
    if (state_q == read_src1 && rd_dn) begin
      op1_q <= rdata;
    end
    if (state_q == alu_begin) begin
      result_q <= alu_res;
    end
  end

  always_comb begin
    case (job_q.op)
      alu_add: alu_res = op0_q + op1_q;
      alu_sub: alu_res = op0_q - op1_q;
      alu_xor: alu_res = op0_q ^ op1_q;
      default: alu_res = op0_q & op1_q;
    endcase
  end

  // request levels held for the whole state
  assign rd_q = (state_q == read_src0) || (state_q == read_src1);
  assign wr_q = (state_q == write_dst);

  // address follows the step
  always_comb begin
    case (state_q)
      read_src0: addr = job_q.src0;
      read_src1: addr = job_q.src1;
      default:   addr = job_q.dst;
    endcase
  end

  assign wdata     = result_q;
  assign seq_state = state_q;
  // one cycle in finish_end, then back to wait
  assign job_done  = (state_q == finish_end);

endmodule

`default_nettype wire

/* logic/core_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module core_bridge #(
  parameter cluster_pkg::slot_t slot_id = '0
) (
  input  wire                          clk,
  input  wire                          ext_rst_b,
  input  wire cluster_pkg::seq_state_t seq_state,
  input  wire                          rd_q,
  input  wire                          wr_q,
  input  wire cluster_pkg::addr_t      addr,
  input  wire cluster_pkg::data_t      wdata,
  output logic                         rd_dn,
  output logic                         wr_dn,
  output logic                         msg_dn,
  output cluster_pkg::data_t           rdata,
  output logic                         core_rst,
  output logic                         core_ready,
  input  wire cluster_pkg::slot_t      poll_slot,
  output cluster_pkg::bus_req_t        bus_req,
  input  wire cluster_pkg::bus_rsp_t   bus_rsp,
  input  wire cluster_pkg::cpu_msg_t   cpu_msg,
  output logic                         active,
  output cluster_pkg::rank_t           rank
);

  import cluster_pkg::*;

  boot_cnt_t            boot_cnt;
  logic                 online;
  // slots currently running, as seen on the broadcast
  logic [num_cores-1:0] run_mask;
  // running slots that started before this one
  logic [num_cores-1:0] lower_mask;

  // power-up steps
  // ready after boot_steps cycles, core released one cycle later
  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      boot_cnt   <= '0;
      core_ready <= 1'b0;
      core_rst   <= 1'b1;
    end else begin
      if (boot_cnt != boot_cnt_t'(boot_steps)) begin
        boot_cnt <= boot_cnt + 1'b1;
      end else begin
        core_ready <= 1'b1;
      end
      core_rst <= ~core_ready;
    end
  end

  // online only in the cycle our slot is polled
  assign online = (poll_slot == slot_id);

  // request gating by sequencer state
  always_comb begin
    bus_req = '0;
    if (online) begin
      case (seq_state)
        read_src0, read_src1: begin
          bus_req.rd   = rd_q;
          bus_req.addr = addr;
        end
        write_dst: begin
          bus_req.wr    = wr_q;
          bus_req.addr  = addr;
          bus_req.wdata = wdata;
        end
        start_begin:  bus_req.msg_kind = msg_start;
        finish_begin: bus_req.msg_kind = msg_end;
        default:      bus_req = '0;
      endcase
    end
  end

  // response goes back as the done pulse for the current step
  assign rd_dn  = bus_rsp.done && (seq_state == read_src0 || seq_state == read_src1);
  assign wr_dn  = bus_rsp.done && (seq_state == write_dst);
  assign msg_dn = bus_rsp.done && (seq_state == start_begin || seq_state == finish_begin);
  assign rdata  = bus_rsp.rdata;

  // rank tracking from start and end broadcasts
  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      active     <= 1'b0;
      run_mask   <= '0;
      lower_mask <= '0;
    end else begin
      case (cpu_msg.kind)
        msg_start: begin
          run_mask[cpu_msg.src] <= 1'b1;
          // own start, everyone running now ranks below us
          if (cpu_msg.src == slot_id) begin
            active     <= 1'b1;
            lower_mask <= run_mask;
          end
        end
        msg_end: begin
          run_mask[cpu_msg.src] <= 1'b0;
          if (cpu_msg.src == slot_id) begin
            active     <= 1'b0;
            lower_mask <= '0;
          end else begin
            // earlier core gone, drop one place
            lower_mask[cpu_msg.src] <= 1'b0;
          end
        end
        default: begin
          active <= active;
        end
      endcase
    end
  end

  // rank is the count of lower slots
  always_comb begin
    rank = '0;
    for (int i = 0; i < num_cores; i++) begin
      rank = rank + rank_t'(lower_mask[i]);
    end
  end

endmodule

`default_nettype wire

/* logic/bus_dispatcher.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_dispatcher (
  input  wire                                                   clk,
  input  wire                                                   ext_rst_b,
  output cluster_pkg::slot_t                                    poll_slot,
  input  wire cluster_pkg::bus_req_t [cluster_pkg::num_cores-1:0] bus_req,
  output cluster_pkg::bus_rsp_t [cluster_pkg::num_cores-1:0]      bus_rsp,
  output cluster_pkg::cpu_msg_t                                 cpu_msg,
  input  wire                                                   host_wr,
  input  wire cluster_pkg::addr_t                               host_addr,
  input  wire cluster_pkg::data_t                               host_wdata,
  output cluster_pkg::data_t                                    host_rdata
);

  import cluster_pkg::*;

  // polled request, served one cycle after the poll
  bus_req_t req_q;
  slot_t    slot_q;
  logic     core_wr;
  logic     req_any;
  data_t    mem [mem_depth];

  // round robin poll and request capture
  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      poll_slot <= '0;
      req_q     <= '0;
      slot_q    <= '0;
    end else begin
      if (poll_slot == slot_t'(num_cores - 1)) begin
        poll_slot <= '0;
      end else begin
        poll_slot <= poll_slot + 1'b1;
      end
      req_q  <= bus_req[poll_slot];
      slot_q <= poll_slot;
    end
  end

  // host wins a same-address collision
  assign core_wr = req_q.wr && !(host_wr && host_addr == req_q.addr);

  // word memory, core port and host port
  always_ff @(posedge clk) begin
    if (core_wr) begin
      mem[req_q.addr] <= req_q.wdata;
    end
    if (host_wr) begin
      mem[host_addr] <= host_wdata;
    end
  end

  // any served access or message
  assign req_any = req_q.rd || req_q.wr || (req_q.msg_kind != msg_none);

  // done only to the slot that was polled
  always_comb begin
    bus_rsp = '0;
    bus_rsp[slot_q].done = req_any;
    if (req_q.rd) begin
      bus_rsp[slot_q].rdata = mem[req_q.addr];
    end
  end

  // message broadcast to every bridge in the serve cycle
  always_comb begin
    cpu_msg.kind = req_q.msg_kind;
    cpu_msg.src  = slot_q;
  end

  // host read is combinational
  assign host_rdata = mem[host_addr];

endmodule

`default_nettype wire

/* logic/cpu_cluster.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_cluster (
  input  wire                                                clk,
  input  wire                                                ext_rst_b,
  input  wire [cluster_pkg::num_cores-1:0]                   job_start,
  input  wire cluster_pkg::job_t [cluster_pkg::num_cores-1:0] job_in,
  output logic [cluster_pkg::num_cores-1:0]                  core_ready,
  output logic [cluster_pkg::num_cores-1:0]                  core_busy,
  output logic [cluster_pkg::num_cores-1:0]                  core_done,
  output cluster_pkg::rank_t [cluster_pkg::num_cores-1:0]    core_rank,
  input  wire                                                host_wr,
  input  wire cluster_pkg::addr_t                            host_addr,
  input  wire cluster_pkg::data_t                            host_wdata,
  output cluster_pkg::data_t                                 host_rdata
);

  import cluster_pkg::*;

  // sequencer to bridge, one entry per core
  seq_state_t           seq_state [num_cores];
  addr_t                seq_addr [num_cores];
  data_t                seq_wdata [num_cores];
  data_t                seq_rdata [num_cores];
  logic [num_cores-1:0] rd_q;
  logic [num_cores-1:0] wr_q;
  logic [num_cores-1:0] rd_dn;
  logic [num_cores-1:0] wr_dn;
  logic [num_cores-1:0] msg_dn;
  logic [num_cores-1:0] core_rst;

  // bridge to dispatcher
  slot_t                      poll_slot;
  bus_req_t [num_cores-1:0]   bus_req;
  bus_rsp_t [num_cores-1:0]   bus_rsp;
  cpu_msg_t                   cpu_msg;

  for (genvar i = 0; i < num_cores; i++) begin : g_core
    core_sequencer u_seq (
      .clk(clk), .ext_rst_b(ext_rst_b), .core_rst(core_rst[i]),
      .job_start(job_start[i]), .job_in(job_in[i]), .seq_state(seq_state[i]),
      .rd_q(rd_q[i]), .wr_q(wr_q[i]), .addr(seq_addr[i]), .wdata(seq_wdata[i]),
      .rd_dn(rd_dn[i]), .wr_dn(wr_dn[i]), .msg_dn(msg_dn[i]),
      .rdata(seq_rdata[i]), .job_done(core_done[i])
    );

    // slot number fixed by position
    core_bridge #(.slot_id(slot_t'(i))) u_bridge (
      .clk(clk), .ext_rst_b(ext_rst_b), .seq_state(seq_state[i]),
      .rd_q(rd_q[i]), .wr_q(wr_q[i]), .addr(seq_addr[i]), .wdata(seq_wdata[i]),
      .rd_dn(rd_dn[i]), .wr_dn(wr_dn[i]), .msg_dn(msg_dn[i]), .rdata(seq_rdata[i]),
      .core_rst(core_rst[i]), .core_ready(core_ready[i]), .poll_slot(poll_slot),
      .bus_req(bus_req[i]), .bus_rsp(bus_rsp[i]), .cpu_msg(cpu_msg),
      .active(core_busy[i]), .rank(core_rank[i])
    );
  end

  bus_dispatcher u_disp (
    .clk(clk), .ext_rst_b(ext_rst_b), .poll_slot(poll_slot),
    .bus_req(bus_req), .bus_rsp(bus_rsp), .cpu_msg(cpu_msg),
    .host_wr(host_wr), .host_addr(host_addr), .host_wdata(host_wdata),
    .host_rdata(host_rdata)
  );

endmodule

`default_nettype wire

/* sim/cpu_cluster_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_cluster_tb;

  import cluster_pkg::*;

  // header, preloads, jobs and expected words of the golden file
  localparam int golden_words = 18;

  logic                     clk = 1'b0;
  logic                     ext_rst_b;
  logic [num_cores-1:0]     job_start;
  job_t [num_cores-1:0]     job_in;
  logic [num_cores-1:0]     core_ready;
  logic [num_cores-1:0]     core_busy;
  logic [num_cores-1:0]     core_done;
  rank_t [num_cores-1:0]    core_rank;
  logic                     host_wr;
  addr_t                    host_addr;
  data_t                    host_wdata;
  data_t                    host_rdata;

  logic [31:0]              golden [golden_words];
  // memory contents as the testbench expects them
  data_t                    shadow [mem_depth];
  data_t                    exp_model [golden_words];
  int                       n_pre;
  int                       n_job;
  // busy cores in start order
  int                       order [$];
  logic [num_cores-1:0]     busy_q = '0;
  logic [num_cores-1:0]     done_seen;
  integer                   seed;
  int                       cycle_cnt = 0;
  int                       cycle_limit = 100000;

  cpu_cluster UUT (
    .clk(clk), .ext_rst_b(ext_rst_b), .job_start(job_start), .job_in(job_in),
    .core_ready(core_ready), .core_busy(core_busy), .core_done(core_done),
    .core_rank(core_rank), .host_wr(host_wr), .host_addr(host_addr),
    .host_wdata(host_wdata), .host_rdata(host_rdata)
  );

  // 20 ns period
  always #10 clk = ~clk;

  task automatic check_data(input string what, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("MISMATCH at %0t ns: %s expected %h got %h", $time, what, exp, act);
      $display("TESTS FAILED");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic check_rank(input int core, input rank_t exp, input rank_t act);
    if (act !== exp) begin
      $display("MISMATCH at %0t ns: core %0d rank expected %0d got %0d",
               $time, core, exp, act);
      $display("TESTS FAILED");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic check_flags(input string what, input logic [num_cores-1:0] exp,
                             input logic [num_cores-1:0] act);
    if (act !== exp) begin
      $display("MISMATCH at %0t ns: %s expected %b got %b", $time, what, exp, act);
      $display("TESTS FAILED");
      $fatal(1, "stopped at first error");
    end
  endtask

  // the four job operations add sub xor and
  function automatic data_t alu_model(input alu_op_t op, input data_t a, input data_t b);
    case (op)
      2'd0:    alu_model = a + b;
      2'd1:    alu_model = a - b;
      2'd2:    alu_model = a ^ b;
      default: alu_model = a & b;
    endcase
  endfunction

  // odd multiplier keeps every address distinct
  function automatic data_t fill_word(input addr_t a);
    fill_word = 16'h5a5a ^ (16'(a) * 16'h0407);
  endfunction

  function automatic int find_pos(input int core);
    find_pos = -1;
    for (int k = 0; k < order.size(); k++) begin
      if (order[k] == core) find_pos = k;
    end
  endfunction

  task automatic write_word(input addr_t a, input data_t d);
    @(negedge clk);
    host_wr    = 1'b1;
    host_addr  = a;
    host_wdata = d;
    @(negedge clk);
    host_wr    = 1'b0;
  endtask

  task automatic read_word(input addr_t a, output data_t d);
    @(negedge clk);
    host_addr = a;
    @(negedge clk);
    d = host_rdata;
  endtask

  // strobe each job after its random delay
  task automatic launch_jobs(input int first, input int last);
    int          delay [num_cores];
    int          max_wait;
    logic [31:0] rec;
    job_t        job;
    max_wait  = 0;
    done_seen = '0;
    for (int j = first; j <= last; j++) begin
      rec = golden[2 + n_pre + j];
      job = job_t'(rec[19:0]);
      delay[j - first] = $unsigned($random(seed)) % (rec[27:20] + 1);
      if (delay[j - first] > max_wait) max_wait = delay[j - first];
      // jobs of one batch never read each other's dst
      exp_model[j] = alu_model(job.op, shadow[job.src0], shadow[job.src1]);
    end
    for (int t = 0; t <= max_wait; t++) begin
      @(negedge clk);
      job_start = '0;
      for (int j = first; j <= last; j++) begin
        rec = golden[2 + n_pre + j];
        if (delay[j - first] == t) begin
          job_start[rec[31:28]] = 1'b1;
          job_in[rec[31:28]]    = job_t'(rec[19:0]);
        end
      end
    end
    @(negedge clk);
    job_start = '0;
  endtask

  // wait for the done pulses and then for all cores idle
  task automatic wait_jobs(input int first, input int last);
    logic [num_cores-1:0] mask;
    mask = '0;
    for (int j = first; j <= last; j++) begin
      mask[golden[2 + n_pre + j][31:28]] = 1'b1;
    end
    while ((done_seen & mask) != mask) @(negedge clk);
    while (core_busy != '0) @(negedge clk);
  endtask

  task automatic check_jobs(input int first, input int last);
    job_t  job;
    data_t got;
    for (int j = first; j <= last; j++) begin
      job = job_t'(golden[2 + n_pre + j][19:0]);
      read_word(job.dst, got);
      check_data("dst word vs ALU model", exp_model[j], got);
      check_data("dst word vs golden", golden[2 + n_pre + n_job + j][15:0], got);
      shadow[job.dst] = exp_model[j];
    end
  endtask

  // start order list and per-cycle rank check
  always @(negedge clk) begin
    int pos;
    if (!ext_rst_b) begin
      for (int i = 0; i < num_cores; i++) begin
        if (core_busy[i] && !busy_q[i]) order.push_back(i);
        if (!core_busy[i] && busy_q[i]) begin
          pos = find_pos(i);
          if (pos >= 0) order.delete(pos);
        end
        if (core_done[i]) done_seen[i] = 1'b1;
      end
      for (int i = 0; i < num_cores; i++) begin
        pos = find_pos(i);
        check_rank(i, core_busy[i] ? rank_t'(pos) : rank_t'(0), core_rank[i]);
      end
      busy_q = core_busy;
    end
  end

  // run limit from the job count
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: run still going after %0d cycles", cycle_cnt);
      $display("TESTS FAILED");
      $fatal(1, "run aborted");
    end
  end

  initial begin
    logic [31:0] rec;
    data_t       got;
    seed       = 32'hbee8;
    ext_rst_b  = 1'b1;
    job_start  = '0;
    job_in     = '0;
    host_wr    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    done_seen  = '0;
    $readmemh("sim/cpu_cluster_golden.mem", golden);
    if ((^golden[0] === 1'bx) || (^golden[1] === 1'bx)) begin
      $display("golden file sim/cpu_cluster_golden.mem could not be read");
      $display("TESTS FAILED");
      $fatal(1, "no stimulus");
    end
    n_pre       = golden[0];
    n_job       = golden[1];
    cycle_limit = 200 * n_job + 100;

    // reset held for three cycles
    repeat (3) @(negedge clk);
    ext_rst_b = 1'b0;
    @(negedge clk);
    check_flags("core_busy after reset", '0, core_busy);
    check_flags("core_done after reset", '0, core_done);
    check_flags("core_ready after reset", '0, core_ready);
    for (int i = 0; i < num_cores; i++) begin
      check_rank(i, '0, core_rank[i]);
    end
    // every bridge counts the same boot steps
    while (core_ready == '0) @(negedge clk);
    check_flags("core_ready rise", '1, core_ready);

    for (int i = 0; i < n_pre; i++) begin
      rec = golden[2 + i];
      write_word(rec[16 +: addr_w], rec[15:0]);
      shadow[rec[16 +: addr_w]] = rec[15:0];
    end

    // first job alone on core 0
    launch_jobs(0, 0);
    wait_jobs(0, 0);
    check_jobs(0, 0);

    // remaining jobs overlap with one per core
    launch_jobs(1, n_job - 1);
    wait_jobs(1, n_job - 1);
    check_jobs(1, n_job - 1);

    // host port over the whole memory including the dst words
    check_flags("core_busy before host writes", '0, core_busy);
    for (int a = 0; a < mem_depth; a++) begin
      write_word(addr_t'(a), fill_word(addr_t'(a)));
    end
    for (int a = 0; a < mem_depth; a++) begin
      read_word(addr_t'(a), got);
      check_data("host readback", fill_word(addr_t'(a)), got);
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/cpu_cluster_golden.mem */
// header: preload count, job count; preload and expected: 00 addr(2) data(4)
// job: core(1) max start delay(2) job word(5) = op src0 src1 dst
00000006
00000005
00011234
00020F0F
000300FF
0004A5A5
00050003
00068001
00001090
01050151
11084092
210C3113
31006194
00102143
00112140
0012AAAA
001300A5
00140002

/* cpu_cluster.f */
logic/cluster_pkg.sv
logic/core_sequencer.sv
logic/core_bridge.sv
logic/bus_dispatcher.sv
logic/cpu_cluster.sv
sim/cpu_cluster_tb.sv
